/* verilog/pacer_pkg.sv */
`default_nettype none

package pacer_pkg;

  localparam int XB_SIZE = 32;  // host word
  localparam int FRAME_W = 24;

  // three host words, the first one lands in the low bits
  typedef struct packed {
    logic [39:0]        reserved_hi;
    logic [FRAME_W-1:0] clock_per_frame;  // bits 55:32
    logic [FRAME_W-1:0] n_frame;          // bits 31:8
    logic               reserved_b7;
    logic               start;            // 1 start, 0 stop
    logic [4:0]         reserved_lo;
    logic               is_data;          // control message when low
  } host_msg_t;

  typedef enum logic [2:0] {
    PACER_STOPPED,
    PACER_INIT,            // filling bank 0
    PACER_STARTING_FRAME,
    PACER_FRAME,
    PACER_STOPPING_FRAME,
    PACER_INTERFRAME
  } pacer_state_t;

  typedef enum logic [7:0] {
    RPT_FRAME_DONE = 8'h01,
    RPT_RUN_DONE   = 8'h02,
    RPT_STOPPED    = 8'h03
  } report_op_t;

  // one host word per report
  typedef struct packed {
    logic [FRAME_W-1:0] frame;
    report_op_t         op;
  } report_t;

endpackage

`default_nettype wire

/* verilog/bank_pkg.sv */
`default_nettype none

package bank_pkg;

  localparam int N_ZMW              = 64;
  localparam int ZMW_W              = 6;   // log2(N_ZMW)
  localparam int BRAM_READ_LATENCY  = 3;
  localparam int CMD_FIFO_DEPTH     = 8;
  localparam int READOUT_FIFO_DEPTH = 16;
  localparam int READOUT_HIGH       = 10;  // leaves room for reads in flight

  typedef enum logic [1:0] {
    OP_STOP,
    OP_START_RD,
    OP_START_WR,
    OP_DATA
  } bank_op_t;

  typedef struct packed {
    bank_op_t         op;
    logic [ZMW_W-1:0] entry;  // payload of OP_DATA only
  } bank_cmd_t;

  typedef enum logic [1:0] {
    BANK_IDLE,
    BANK_WRITING,
    BANK_READING,
    BANK_THROTTLED
  } bank_state_t;

endpackage

`default_nettype wire

/* verilog/sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

// circular buffer, DEPTH must be a power of two
module sync_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 8,
  parameter int HIGH  = DEPTH - 1
) (
  input  wire              CLK,
  input  wire              RESET,
  input  wire              wr,
  input  wire  [WIDTH-1:0] din,
  input  wire              rd,
  output logic [WIDTH-1:0] dout,
  output logic             full,
  output logic             high,
  output logic             empty
);
  logic [WIDTH-1:0]         mem [DEPTH];
  logic [$clog2(DEPTH)-1:0] wr_ptr, rd_ptr;
  logic [$clog2(DEPTH):0]   count;
  logic                     wr_ok, rd_ok;

  assign wr_ok = wr && !full;   // writes into a full FIFO are dropped
  assign rd_ok = rd && !empty;

  assign dout  = mem[rd_ptr];   // head, valid while not empty
  assign full  = count == DEPTH[$clog2(DEPTH):0];
  assign high  = count >= HIGH[$clog2(DEPTH):0];
  assign empty = count == '0;

  always_ff @(posedge CLK) begin
    if (wr_ok) mem[wr_ptr] <= din;
  end

  always_ff @(posedge CLK) begin
    if (RESET) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_ok) wr_ptr <= wr_ptr + 1'b1;  // wraps at DEPTH
      if (rd_ok) rd_ptr <= rd_ptr + 1'b1;
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/host_msg_assembler.sv */
`timescale 1ns/1ps
`default_nettype none

module host_msg_assembler (
  input  wire                           CLK,
  input  wire                           RESET,
  input  wire                           pc_msg_valid,
  input  wire  [pacer_pkg::XB_SIZE-1:0] pc_msg,
  output logic                          pc_msg_ack,
  output logic                          msg_valid,
  output pacer_pkg::host_msg_t          host_msg
);
  import pacer_pkg::*;

  logic [1:0]           word_idx;  // which of the three words comes next
  logic [2*XB_SIZE-1:0] cache;

  // the host never waits
  assign pc_msg_ack = pc_msg_valid;

  always_ff @(posedge CLK) begin
    if (RESET) begin
      word_idx  <= 2'd0;
      msg_valid <= 1'b0;
    end else begin
      msg_valid <= 1'b0;
      if (pc_msg_valid) begin
        if (word_idx == 2'd2) begin
          word_idx  <= 2'd0;
          msg_valid <= 1'b1;  // one cycle pulse
        end else begin
          word_idx <= word_idx + 1'b1;
        end
      end
    end
  end

  // word cache and the assembled message
  always_ff @(posedge CLK) begin
    if (pc_msg_valid) begin
      case (word_idx)
        2'd0:    cache[0 +: XB_SIZE]       <= pc_msg;
        2'd1:    cache[XB_SIZE +: XB_SIZE] <= pc_msg;
        default: host_msg                  <= {pc_msg, cache};
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/frame_pacer.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_pacer (
  input  wire                          CLK,
  input  wire                          RESET,
  input  wire                          msg_valid,
  input  wire pacer_pkg::host_msg_t    host_msg,
  output logic [1:0]                   cmd_wr,
  output bank_pkg::bank_cmd_t          cmd0,
  output bank_pkg::bank_cmd_t          cmd1,
  input  wire  [1:0]                   cmd_full,
  input  wire                          entry_valid,
  input  wire  [bank_pkg::ZMW_W-1:0]   entry,
  output logic                         entry_ready,
  output logic                         rpt_req,
  output pacer_pkg::report_t           rpt,
  input  wire                          rpt_busy,
  output logic                         app_running
);
  import pacer_pkg::*;
  import bank_pkg::*;

  pacer_state_t       state;
  logic [FRAME_W-1:0] max_frame, frame_cnt;
  logic [FRAME_W-1:0] clock_per_frame, n_clock;
  logic [ZMW_W:0]     init_idx;      // 0 start, 1..N_ZMW data, N_ZMW+1 stop
  logic [ZMW_W-1:0]   fwd_cnt;
  logic               src, dst;      // bank read / bank written this frame
  logic               stop_pending;
  logic               start_msg, stop_msg, run_end;

  assign start_msg = msg_valid && !host_msg.is_data && host_msg.start;
  assign stop_msg  = msg_valid && !host_msg.is_data && !host_msg.start;
  assign dst       = ~src;
  assign run_end   = (frame_cnt == max_frame) || stop_pending;

  assign app_running = state != PACER_STOPPED;

  always_comb begin
    cmd_wr      = 2'b00;
    cmd0        = '{op: OP_STOP, entry: '0};
    cmd1        = '{op: OP_STOP, entry: '0};
    entry_ready = 1'b0;
    rpt_req     = 1'b0;
    rpt         = '{frame: frame_cnt, op: RPT_FRAME_DONE};
    case (state)
      PACER_INIT: begin
        cmd_wr[0] = !cmd_full[0];
        if (init_idx == '0) begin
          cmd0.op = OP_START_WR;
        end else if (init_idx != (ZMW_W + 1)'(N_ZMW + 1)) begin
          cmd0 = '{op: OP_DATA, entry: ZMW_W'(init_idx - 1'b1)};
        end
      end
      PACER_STARTING_FRAME: begin
        if (cmd_full == 2'b00) cmd_wr = 2'b11;  // both banks at once
        cmd0.op = src ? OP_START_WR : OP_START_RD;
        cmd1.op = src ? OP_START_RD : OP_START_WR;
      end
      PACER_FRAME: begin
        entry_ready = !cmd_full[dst];
        cmd_wr[dst] = entry_valid && !cmd_full[dst];
        cmd0        = '{op: OP_DATA, entry: entry};
        cmd1        = '{op: OP_DATA, entry: entry};
      end
      PACER_STOPPING_FRAME: begin
        // stop to the written bank together with the frame report
        rpt_req     = !(cmd_full[dst] || rpt_busy);
        cmd_wr[dst] = !(cmd_full[dst] || rpt_busy);
      end
      PACER_INTERFRAME: begin
        if (run_end) begin
          rpt_req = !rpt_busy;
          rpt.op  = (frame_cnt == max_frame) ? RPT_RUN_DONE : RPT_STOPPED;
        end
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge CLK) begin
    if (RESET) begin
      state           <= PACER_STOPPED;
      max_frame       <= '0;
      frame_cnt       <= '0;
      clock_per_frame <= '0;
      n_clock         <= '0;
      init_idx        <= '0;
      fwd_cnt         <= '0;
      src             <= 1'b0;
      stop_pending    <= 1'b0;
    end else begin
      if (state != PACER_STOPPED) n_clock <= n_clock + 1'b1;
      if (stop_msg && state != PACER_STOPPED) stop_pending <= 1'b1;
      case (state)
        PACER_STOPPED:
          if (start_msg) begin
            max_frame       <= host_msg.n_frame;
            clock_per_frame <= host_msg.clock_per_frame;
            frame_cnt       <= '0;
            init_idx        <= '0;
            src             <= 1'b0;  // bank 0 holds the first list
            stop_pending    <= 1'b0;
            state           <= PACER_INIT;
          end
        PACER_INIT:
          if (cmd_wr[0]) begin
            init_idx <= init_idx + 1'b1;
            if (init_idx == (ZMW_W + 1)'(N_ZMW + 1)) begin
              n_clock <= clock_per_frame;  // no wait before frame 1
              state   <= PACER_INTERFRAME;
            end
          end
        PACER_STARTING_FRAME:
          if (cmd_wr == 2'b11) begin
            frame_cnt <= frame_cnt + 1'b1;
            fwd_cnt   <= '0;
            state     <= PACER_FRAME;
          end
        PACER_FRAME:
          if (cmd_wr[dst]) begin
            fwd_cnt <= fwd_cnt + 1'b1;
            if (fwd_cnt == ZMW_W'(N_ZMW - 1)) state <= PACER_STOPPING_FRAME;
          end
        PACER_STOPPING_FRAME:
          if (rpt_req) begin
            src   <= dst;  // swap banks
            state <= PACER_INTERFRAME;
          end
        PACER_INTERFRAME:
          if (rpt_req) begin
            state <= PACER_STOPPED;
          end else if (!run_end && n_clock >= clock_per_frame) begin
            n_clock <= '0;
            state   <= PACER_STARTING_FRAME;
          end
        default: state <= PACER_STOPPED;
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/pulse_list_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module pulse_list_bank (
  input  wire                        CLK,
  input  wire                        RESET,
  input  wire                        cmd_wr,
  input  wire bank_pkg::bank_cmd_t   cmd,
  output logic                       cmd_full,
  input  wire                        readout_high,
  output logic                       rd_valid,
  output logic [bank_pkg::ZMW_W-1:0] rd_entry
);
  import bank_pkg::*;

  bank_state_t                  state;
  bank_cmd_t                    head;
  logic                         cmd_empty, cmd_pop;
  logic [ZMW_W-1:0]             addr, wdata;
  logic                         ram_en, ram_we;
  logic [ZMW_W-1:0]             mem [N_ZMW];
  logic [ZMW_W-1:0]             rd_pipe [BRAM_READ_LATENCY];
  logic [BRAM_READ_LATENCY-1:0] vld_pipe;

  sync_fifo #(
    .WIDTH($bits(bank_cmd_t)),
    .DEPTH(CMD_FIFO_DEPTH)
  ) cmd_fifo_inst (
    .CLK(CLK), .RESET(RESET),
    .wr(cmd_wr), .din(cmd),
    .rd(cmd_pop), .dout(head),
    .full(cmd_full), .high(), .empty(cmd_empty)
  );

  // a reading bank only listens for stop
  assign cmd_pop = !cmd_empty &&
                   (state == BANK_IDLE || state == BANK_WRITING || head.op == OP_STOP);

  always_ff @(posedge CLK) begin
    if (RESET) begin
      state  <= BANK_IDLE;
      addr   <= '0;
      ram_en <= 1'b0;
      ram_we <= 1'b0;
    end else if (cmd_pop && head.op == OP_STOP) begin
      ram_en <= 1'b0;
      state  <= BANK_IDLE;
    end else begin
      case (state)
        BANK_IDLE: begin
          ram_en <= 1'b0;
          if (cmd_pop && head.op == OP_START_WR) begin
            addr  <= '1;  // first OP_DATA wraps to 0
            state <= BANK_WRITING;
          end else if (cmd_pop && head.op == OP_START_RD) begin
            addr   <= '0;
            ram_en <= 1'b1;
            ram_we <= 1'b0;
            state  <= BANK_READING;
          end
        end
        BANK_WRITING: begin
          ram_en <= cmd_pop && head.op == OP_DATA;
          ram_we <= 1'b1;
          if (cmd_pop && head.op == OP_DATA) begin
            addr  <= addr + 1'b1;
            wdata <= head.entry;
          end
        end
        BANK_READING:  // address issued this cycle
          if (addr == ZMW_W'(N_ZMW - 1)) begin
            ram_en <= 1'b0;
            state  <= BANK_IDLE;
          end else begin
            addr <= addr + 1'b1;
            if (readout_high) begin
              ram_en <= 1'b0;
              state  <= BANK_THROTTLED;
            end
          end
        default:  // BANK_THROTTLED
          if (!readout_high) begin
            ram_en <= 1'b1;
            state  <= BANK_READING;
          end
      endcase
    end
  end

  // list RAM with registered read, then the latency stages
  always_ff @(posedge CLK) begin
    if (ram_en) begin
      if (ram_we) mem[addr] <= wdata;
      rd_pipe[0] <= mem[addr];
    end
    for (int i = 1; i < BRAM_READ_LATENCY; i++) rd_pipe[i] <= rd_pipe[i-1];
  end

  always_ff @(posedge CLK) begin
    if (RESET) vld_pipe <= '0;
    else vld_pipe <= {vld_pipe[BRAM_READ_LATENCY-2:0], ram_en && !ram_we};
  end

  assign rd_valid = vld_pipe[BRAM_READ_LATENCY-1];
  assign rd_entry = rd_pipe[BRAM_READ_LATENCY-1];

endmodule

`default_nettype wire

/* verilog/readout_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

module readout_monitor (
  input  wire                        CLK,
  input  wire                        RESET,
  input  wire  [1:0]                 rd_valid,
  input  wire  [bank_pkg::ZMW_W-1:0] rd_entry0,
  input  wire  [bank_pkg::ZMW_W-1:0] rd_entry1,
  output logic                       readout_high,
  output logic                       entry_valid,
  output logic [bank_pkg::ZMW_W-1:0] entry,
  input  wire                        entry_ready,
  input  wire                        rpt_req,
  input  wire pacer_pkg::report_t    rpt,
  output logic                       rpt_busy,
  output logic                       fpga_msg_valid,
  output pacer_pkg::report_t         fpga_msg,
  input  wire                        fpga_msg_ready
);
  import pacer_pkg::*;
  import bank_pkg::*;

  logic [ZMW_W-1:0] merged;
  logic             entry_empty, rpt_empty;

  // only one bank reads at a time, idle stream masked to zero
  assign merged = ({ZMW_W{rd_valid[0]}} & rd_entry0) | ({ZMW_W{rd_valid[1]}} & rd_entry1);

  sync_fifo #(
    .WIDTH(ZMW_W),
    .DEPTH(READOUT_FIFO_DEPTH),
    .HIGH(READOUT_HIGH)
  ) readout_fifo_inst (
    .CLK(CLK), .RESET(RESET),
    .wr(|rd_valid), .din(merged),
    .rd(entry_ready), .dout(entry),
    .full(), .high(readout_high), .empty(entry_empty)
  );

  assign entry_valid = !entry_empty;

  // report holding slot, busy as soon as one report waits
  sync_fifo #(
    .WIDTH($bits(report_t)),
    .DEPTH(2),
    .HIGH(1)
  ) report_fifo_inst (
    .CLK(CLK), .RESET(RESET),
    .wr(rpt_req), .din(rpt),
    .rd(fpga_msg_ready), .dout(fpga_msg),
    .full(), .high(rpt_busy), .empty(rpt_empty)
  );

  assign fpga_msg_valid = !rpt_empty;

endmodule

`default_nettype wire

/* verilog/application_top.sv */
`timescale 1ns/1ps
`default_nettype none

module application_top (
  input  wire                           CLK,
  input  wire                           RESET,
  input  wire                           pc_msg_valid,
  input  wire  [pacer_pkg::XB_SIZE-1:0] pc_msg,
  output logic                          pc_msg_ack,
  output logic                          fpga_msg_valid,
  output pacer_pkg::report_t            fpga_msg,
  input  wire                           fpga_msg_ready,
  output logic                          app_running
);
  import pacer_pkg::*;
  import bank_pkg::*;

  logic             msg_valid;
  host_msg_t        host_msg;
  logic [1:0]       cmd_wr, cmd_full, rd_valid;
  bank_cmd_t        cmd0, cmd1;
  logic [ZMW_W-1:0] rd_entry0, rd_entry1, entry;
  logic             readout_high, entry_valid, entry_ready;
  logic             rpt_req, rpt_busy;
  report_t          rpt;

  host_msg_assembler msg_assembler_inst (
    .CLK(CLK), .RESET(RESET),
    .pc_msg_valid(pc_msg_valid), .pc_msg(pc_msg), .pc_msg_ack(pc_msg_ack),
    .msg_valid(msg_valid), .host_msg(host_msg)
  );

  frame_pacer pacer_inst (
    .CLK(CLK), .RESET(RESET),
    .msg_valid(msg_valid), .host_msg(host_msg),
    .cmd_wr(cmd_wr), .cmd0(cmd0), .cmd1(cmd1), .cmd_full(cmd_full),
    .entry_valid(entry_valid), .entry(entry), .entry_ready(entry_ready),
    .rpt_req(rpt_req), .rpt(rpt), .rpt_busy(rpt_busy),
    .app_running(app_running)
  );

  pulse_list_bank bank0_inst (
    .CLK(CLK), .RESET(RESET),
    .cmd_wr(cmd_wr[0]), .cmd(cmd0), .cmd_full(cmd_full[0]),
    .readout_high(readout_high), .rd_valid(rd_valid[0]), .rd_entry(rd_entry0)
  );

  pulse_list_bank bank1_inst (
    .CLK(CLK), .RESET(RESET),
    .cmd_wr(cmd_wr[1]), .cmd(cmd1), .cmd_full(cmd_full[1]),
    .readout_high(readout_high), .rd_valid(rd_valid[1]), .rd_entry(rd_entry1)
  );

  readout_monitor monitor_inst (
    .CLK(CLK), .RESET(RESET),
    .rd_valid(rd_valid), .rd_entry0(rd_entry0), .rd_entry1(rd_entry1),
    .readout_high(readout_high),
    .entry_valid(entry_valid), .entry(entry), .entry_ready(entry_ready),
    .rpt_req(rpt_req), .rpt(rpt), .rpt_busy(rpt_busy),
    .fpga_msg_valid(fpga_msg_valid), .fpga_msg(fpga_msg),
    .fpga_msg_ready(fpga_msg_ready)
  );

endmodule

`default_nettype wire

/* tb/tb_application.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_application;
  import pacer_pkg::*;
  import bank_pkg::*;

  localparam int NRUN        = 5;
  localparam int MIN_GAP_CPF = 400;  // frame pacing checked from here up

  logic               CLK = 1'b0;
  logic               RESET;
  logic               pc_msg_valid;
  logic [XB_SIZE-1:0] pc_msg;
  logic               pc_msg_ack;
  logic               fpga_msg_valid;
  report_t            fpga_msg;
  logic               fpga_msg_ready = 1'b0;
  logic               app_running;

  report_t     expected[$];  // predicted reports in order
  int unsigned rpt_count;    // reports taken by the host so far
  int unsigned cycle_cnt;
  int unsigned last_frame_cycle;
  int unsigned run_id, gap_run;
  int unsigned cur_cpf;
  int unsigned budget;
  bit          valid_q;
  int unsigned run_f [NRUN];
  int unsigned run_cpf [NRUN];
  int unsigned run_stop [NRUN];  // 0 means the run ends by itself

  application_top application_top_inst (
    .CLK(CLK), .RESET(RESET),
    .pc_msg_valid(pc_msg_valid), .pc_msg(pc_msg), .pc_msg_ack(pc_msg_ack),
    .fpga_msg_valid(fpga_msg_valid), .fpga_msg(fpga_msg),
    .fpga_msg_ready(fpga_msg_ready), .app_running(app_running)
  );

  always #2 CLK = ~CLK;

  task automatic abort_run();
    $display("Verification failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, exp);
      abort_run();
    end
  endtask

  // host side of the report stream
  always @(posedge CLK) begin
    #1;
    fpga_msg_ready = RESET ? 1'b0 : 1'($urandom_range(1, 0));
  end

  task automatic note_arrival();
    report_t exp;
    if (rpt_count >= expected.size()) begin
      $display("unexpected report 0x%08h while no report was due", fpga_msg);
      abort_run();
    end else begin
      exp = expected[rpt_count];
      if (exp.op == RPT_FRAME_DONE) begin
        check("app_running", 32'(app_running), 32'd1);
        if (gap_run == run_id && cur_cpf >= MIN_GAP_CPF &&
            cycle_cnt - last_frame_cycle < cur_cpf) begin
          $display("frame reports only %0d cycles apart, clock_per_frame is %0d",
                   cycle_cnt - last_frame_cycle, cur_cpf);
          abort_run();
        end
        last_frame_cycle = cycle_cnt;
        gap_run          = run_id;
      end else begin
        check("app_running", 32'(app_running), 32'd0);  // run already over
      end
    end
  endtask

  // a report counts where valid and ready meet mid-cycle
  always @(negedge CLK) begin
    cycle_cnt++;
    if (!RESET) begin
      if (fpga_msg_valid && !valid_q) note_arrival();
      if (fpga_msg_valid && fpga_msg_ready) begin
        check("fpga_msg", fpga_msg, expected[rpt_count]);
        rpt_count++;
      end
    end
    valid_q = fpga_msg_valid;
  end

  initial begin
    wait (budget != 0);
    repeat (budget) @(posedge CLK);
    $display("timeout, the tests did not finish within %0d cycles", budget);
    abort_run();
  end

  function automatic logic [XB_SIZE-1:0] ctrl_word0(input logic start, input int unsigned n);
    return {FRAME_W'(n), 1'b0, start, 5'b0, 1'b0};
  endfunction

  // enters and leaves 1 ns after a rising edge
  task automatic send_word(input logic [XB_SIZE-1:0] w);
    int unsigned gap;
    gap = $urandom_range(3, 0);
    repeat (gap) begin
      @(posedge CLK);
      #1;
    end
    pc_msg_valid = 1'b1;
    pc_msg       = w;
    @(negedge CLK);
    check("pc_msg_ack", 32'(pc_msg_ack), 32'd1);
    @(posedge CLK);  // word taken here
    #1;
    pc_msg_valid = 1'b0;
    pc_msg       = $urandom;  // junk while idle
  endtask

  task automatic send_msg(input logic [XB_SIZE-1:0] w0, w1, w2);
    send_word(w0);
    send_word(w1);
    send_word(w2);
  endtask

  // stop pattern with is_data set
  task automatic send_data_msg();
    send_msg(($urandom & ~32'h40) | 32'h1, $urandom, $urandom);
  endtask

  task automatic idle_check(input int unsigned n);
    repeat (n) begin
      @(negedge CLK);
      check("app_running", 32'(app_running), 32'd0);
      check("fpga_msg_valid", 32'(fpga_msg_valid), 32'd0);
      check("pc_msg_ack", 32'(pc_msg_ack), 32'd0);
    end
    @(posedge CLK);
    #1;
  endtask

  task automatic do_run(input int unsigned f, input int unsigned cpf, input int unsigned stop_k);
    int unsigned last;
    int unsigned base;
    int unsigned n_data;
    last = (stop_k != 0) ? stop_k : f;
    base = rpt_count;
    for (int i = 1; i <= int'(last); i++) begin
      expected.push_back(report_t'{frame: FRAME_W'(i), op: RPT_FRAME_DONE});
    end
    if (stop_k != 0) expected.push_back(report_t'{frame: FRAME_W'(last), op: RPT_STOPPED});
    else expected.push_back(report_t'{frame: FRAME_W'(last), op: RPT_RUN_DONE});
    run_id++;
    cur_cpf = cpf;
    send_msg(ctrl_word0(1'b1, f), {8'h00, FRAME_W'(cpf)}, $urandom);
    repeat (2) @(negedge CLK);  // message pulse and then the pacer leaves stopped
    check("app_running", 32'(app_running), 32'd1);
    @(posedge CLK);
    #1;
    n_data = $urandom_range(2, 1);
    repeat (n_data) send_data_msg();  // ignored while running
    if (stop_k != 0) begin
      do begin
        @(posedge CLK);
      end while (rpt_count < base + stop_k);
      #1;
      send_msg(ctrl_word0(1'b0, $urandom), $urandom, $urandom);
    end
    do begin
      @(posedge CLK);
    end while (rpt_count < expected.size());
    #1;
  endtask

  initial begin
    void'($urandom(6199));
    RESET        = 1'b1;
    pc_msg_valid = 1'b0;
    pc_msg       = '0;
    for (int i = 0; i < NRUN; i++) begin
      run_f[i]    = $urandom_range(4, 1);
      run_cpf[i]  = $urandom_range(799, 400);
      run_stop[i] = 0;
    end
    run_f[0]         = $urandom_range(4, 2);  // at least one paced gap to measure
    run_cpf[NRUN-2]  = $urandom_range(40, 0);  // frame work sets the pace here
    run_f[NRUN-1]    = $urandom_range(4, 2);
    run_cpf[NRUN-1]  = 2000;
    run_stop[NRUN-1] = $urandom_range(run_f[NRUN-1] - 1, 1);
    budget = 1000;
    for (int i = 0; i < NRUN; i++) begin
      budget += (run_f[i] + 1) * (run_cpf[i] + 1 + 8 * N_ZMW) + 4 * N_ZMW + 300;
    end

    repeat (3) @(posedge CLK);
    #1;
    RESET = 1'b0;

    idle_check(20);
    send_msg(ctrl_word0(1'b1, 2) | 32'h1, 32'd100, $urandom);  // start pattern with is_data set
    send_msg(ctrl_word0(1'b0, 3), 32'd100, $urandom);  // stop while already stopped
    idle_check(20);

    for (int i = 0; i < NRUN; i++) begin
      do_run(run_f[i], run_cpf[i], run_stop[i]);
      idle_check(30);
    end

    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
verilog/pacer_pkg.sv
verilog/bank_pkg.sv
verilog/sync_fifo.sv
verilog/host_msg_assembler.sv
verilog/frame_pacer.sv
verilog/pulse_list_bank.sv
verilog/readout_monitor.sv
verilog/application_top.sv
tb/tb_application.sv

/* Makefile */
TOP = tb_application

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f sim.f

sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -f sim.f \
		--Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir
